// ==== Bender.yml ====
package:
  name: lcd_binary_display

sources:
  # design sources in compile order
  - include_dirs:
      - hdl
    files:
      - hdl/lcdPkg.sv
      - hdl/lcdInit.sv
      - hdl/lineFormatter.sv
      - hdl/lcdArbiter.sv
      - hdl/lcdBusDriver.sv
      - hdl/lcdBinaryDisplay.sv
  # testbench, top module lcdBinaryDisplayTb
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/lcdBinaryDisplayTb.sv

// ==== hdl/lcdArbiter.sv ====
`timescale 1ns/1ns

module lcdArbiter (
	input logic clock,
	input logic rstN,
	input lcdPkg::lcdCharReq_t initReq,
	input logic initValid,
	output logic initReady,
	input lcdPkg::lcdCharReq_t row0Req,
	input logic row0Valid,
	output logic row0Ready,
	input lcdPkg::lcdCharReq_t row1Req,
	input logic row1Valid,
	output logic row1Ready,
	output lcdPkg::lcdCharReq_t busReq,
	output logic busValid,
	input logic busReady
);

	typedef enum logic [1:0] {GRANT_INIT, GRANT_ROW0, GRANT_ROW1} grant_t;

	grant_t grant;
	grant_t pick;
	logic pickValid;
	logic locked;
	// high once the setup commands are through, rows wait until then
	logic initDone;
	// low prefers row 0 when both rows are waiting
	logic rrPtr;
	logic lastDone;

	assign lastDone = locked && busValid && busReady && busReq.last;

	// choose the next owner, the initializer always wins
	always_comb begin
		pick = GRANT_INIT;
		pickValid = 1'b1;
		if (initValid)
			pick = GRANT_INIT;
		else if (initDone && row0Valid && row1Valid)
			pick = rrPtr ? GRANT_ROW1 : GRANT_ROW0;
		else if (initDone && row0Valid)
			pick = GRANT_ROW0;
		else if (initDone && row1Valid)
			pick = GRANT_ROW1;
		else
			pickValid = 1'b0;
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			grant <= GRANT_INIT;
			locked <= 1'b0;
			initDone <= 1'b0;
			rrPtr <= 1'b0;
		end else if (!locked) begin
			if (pickValid) begin
				grant <= pick;
				locked <= 1'b1;
			end
		end else if (lastDone) begin
			// the transfer is complete, release and step the pointer past this row
			locked <= 1'b0;
			case (grant)
				GRANT_INIT: initDone <= 1'b1;
				GRANT_ROW0: rrPtr <= 1'b1;
				default: rrPtr <= 1'b0;
			endcase
		end
	end

	// the owner sees the bus handshake directly, everyone else sees ready low
	always_comb begin
		busReq = initReq;
		busValid = 1'b0;
		initReady = 1'b0;
		row0Ready = 1'b0;
		row1Ready = 1'b0;
		if (locked) begin
			case (grant)
				GRANT_INIT: begin
					busReq = initReq;
					busValid = initValid;
					initReady = busReady;
				end
				GRANT_ROW0: begin
					busReq = row0Req;
					busValid = row0Valid;
					row0Ready = busReady;
				end
				default: begin
					busReq = row1Req;
					busValid = row1Valid;
					row1Ready = busReady;
				end
			endcase
		end
	end

endmodule

// ==== hdl/lcdBinaryDisplay.sv ====
`timescale 1ns/1ns

module lcdBinaryDisplay (
	input logic clock,
	input logic rstN,
	input logic [15:0] line0Value,
	input logic line0Valid,
	output logic line0Ready,
	input logic [15:0] line1Value,
	input logic line1Valid,
	output logic line1Ready,
	output logic lcdOn,
	output logic lcdBlon,
	output logic lcdRw,
	output logic lcdEn,
	output logic lcdRs,
	output logic [7:0] lcdData
);

	lcdPkg::lcdCharReq_t initReq;
	lcdPkg::lcdCharReq_t row0Req;
	lcdPkg::lcdCharReq_t row1Req;
	lcdPkg::lcdCharReq_t busReq;
	logic initValid;
	logic initReady;
	logic row0Valid;
	logic row0Ready;
	logic row1Valid;
	logic row1Ready;
	logic busValid;
	logic busReady;

	// setup commands, sent once after reset
	lcdInit lcdInit_i (
		.clock(clock),
		.rstN(rstN),
		.req(initReq),
		.reqValid(initValid),
		.reqReady(initReady)
	);

	// top row formatter
	lineFormatter #(
		.ROW_ADDR(lcdPkg::CMD_ROW0_ADDR)
	) lineFormatter0_i (
		.clock(clock),
		.rstN(rstN),
		.lineValue(line0Value),
		.lineValid(line0Valid),
		.lineReady(line0Ready),
		.req(row0Req),
		.reqValid(row0Valid),
		.reqReady(row0Ready)
	);

	// bottom row formatter
	lineFormatter #(
		.ROW_ADDR(lcdPkg::CMD_ROW1_ADDR)
	) lineFormatter1_i (
		.clock(clock),
		.rstN(rstN),
		.lineValue(line1Value),
		.lineValid(line1Valid),
		.lineReady(line1Ready),
		.req(row1Req),
		.reqValid(row1Valid),
		.reqReady(row1Ready)
	);

	// one owner of the write bus at a time, held for a whole transfer
	lcdArbiter lcdArbiter_i (
		.clock(clock),
		.rstN(rstN),
		.initReq(initReq),
		.initValid(initValid),
		.initReady(initReady),
		.row0Req(row0Req),
		.row0Valid(row0Valid),
		.row0Ready(row0Ready),
		.row1Req(row1Req),
		.row1Valid(row1Valid),
		.row1Ready(row1Ready),
		.busReq(busReq),
		.busValid(busValid),
		.busReady(busReady)
	);

	// pin timing toward the display
	lcdBusDriver lcdBusDriver_i (
		.clock(clock),
		.rstN(rstN),
		.busReq(busReq),
		.busValid(busValid),
		.busReady(busReady),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdData(lcdData)
	);

	// panel power and backlight stay on
	assign lcdOn = 1'b1;
	assign lcdBlon = 1'b1;

endmodule

// ==== hdl/lcdBusDriver.sv ====
`timescale 1ns/1ns
`include "lcdTiming_macros.svh"

module lcdBusDriver (
	input logic clock,
	input logic rstN,
	input lcdPkg::lcdCharReq_t busReq,
	input logic busValid,
	output logic busReady,
	output logic lcdRs,
	output logic lcdRw,
	output logic lcdEn,
	output logic [7:0] lcdData
);

	// the counter has to hold the longest of the phase lengths
	localparam int MAX_A = (`LCD_SETUP_CYCLES > `LCD_PULSE_CYCLES) ?
		`LCD_SETUP_CYCLES : `LCD_PULSE_CYCLES;
	localparam int MAX_B = (`LCD_WAIT_CYCLES > `LCD_CLEAR_WAIT_CYCLES) ?
		`LCD_WAIT_CYCLES : `LCD_CLEAR_WAIT_CYCLES;
	localparam int MAX_CYC = (MAX_A > MAX_B) ? MAX_A : MAX_B;
	localparam int CNT_W = $clog2(MAX_CYC + 1);

	// terminal counts of each phase
	localparam logic [CNT_W-1:0] SETUP_LAST = CNT_W'(`LCD_SETUP_CYCLES - 1);
	localparam logic [CNT_W-1:0] PULSE_LAST = CNT_W'(`LCD_PULSE_CYCLES - 1);
	localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(`LCD_WAIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] CLEAR_LAST = CNT_W'(`LCD_CLEAR_WAIT_CYCLES - 1);

	typedef enum logic [1:0] {IDLE, SETUP, PULSE, SETTLE} busState_t;

	busState_t state;
	logic [CNT_W-1:0] cycleCnt;
	logic longWait;
	logic rsReg;
	logic [7:0] dataReg;
	logic [CNT_W-1:0] settleLast;

	// only a clear instruction needs the long settle time
	assign settleLast = longWait ? CLEAR_LAST : WAIT_LAST;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= IDLE;
			cycleCnt <= '0;
			longWait <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (busValid) begin
						state <= SETUP;
						cycleCnt <= '0;
						longWait <= !busReq.rs && (busReq.data == lcdPkg::CMD_CLEAR);
					end
				end
				SETUP: begin
					if (cycleCnt == SETUP_LAST) begin
						state <= PULSE;
						cycleCnt <= '0;
					end else
						cycleCnt <= cycleCnt + 1'b1;
				end
				PULSE: begin
					// the display latches on the falling edge at the end of this phase
					if (cycleCnt == PULSE_LAST) begin
						state <= SETTLE;
						cycleCnt <= '0;
					end else
						cycleCnt <= cycleCnt + 1'b1;
				end
				default: begin
					if (cycleCnt == settleLast)
						state <= IDLE;
					else
						cycleCnt <= cycleCnt + 1'b1;
				end
			endcase
		end
	end

	// rs and data stay put from acceptance until the next item is taken
	// so they are stable across setup, pulse and settle
	always_ff @(posedge clock) begin
		if (!rstN) begin
			rsReg <= 1'b0;
			dataReg <= '0;
		end else if (state == IDLE && busValid) begin
			rsReg <= busReq.rs;
			dataReg <= busReq.data;
		end
	end

	assign busReady = (state == IDLE);
	assign lcdEn = (state == PULSE);
	assign lcdRs = rsReg;
	assign lcdData = dataReg;
	// the display is never read, so the bus is always in write mode
	assign lcdRw = 1'b0;

endmodule

// ==== hdl/lcdInit.sv ====
`timescale 1ns/1ns
`include "lcdTiming_macros.svh"

module lcdInit (
	input logic clock,
	input logic rstN,
	output lcdPkg::lcdCharReq_t req,
	output logic reqValid,
	input logic reqReady
);

	localparam int PWR_W = $clog2(`LCD_POWERUP_CYCLES + 1);
	localparam logic [PWR_W-1:0] PWR_LAST = PWR_W'(`LCD_POWERUP_CYCLES - 1);

	typedef enum logic [1:0] {POWER_WAIT, SEND, DONE} initState_t;

	initState_t state;
	logic [PWR_W-1:0] powerCnt;
	logic [1:0] step;

	// wait out the power-up time, then hand the four commands over as one transfer
	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= POWER_WAIT;
			powerCnt <= '0;
			step <= '0;
		end else begin
			case (state)
				POWER_WAIT: begin
					if (powerCnt == PWR_LAST)
						state <= SEND;
					else
						powerCnt <= powerCnt + 1'b1;
				end
				SEND: begin
					if (reqReady) begin
						step <= step + 1'b1;
						// the clear was the fourth command, nothing is ever sent again
						if (step == 2'd3)
							state <= DONE;
					end
				end
				default: state <= DONE;
			endcase
		end
	end

	// command order follows the HD44780 eight-bit setup sequence
	always_comb begin
		req.rs = 1'b0;
		req.last = (step == 2'd3);
		case (step)
			2'd0: req.data = lcdPkg::CMD_FUNCTION_SET;
			2'd1: req.data = lcdPkg::CMD_DISPLAY_ON;
			2'd2: req.data = lcdPkg::CMD_ENTRY_MODE;
			default: req.data = lcdPkg::CMD_CLEAR;
		endcase
	end

	assign reqValid = (state == SEND);

endmodule

// ==== hdl/lcdPkg.sv ====
// shared types and HD44780 command bytes for the binary value display
package lcdPkg;

	// one write toward the display
	// it is passed from a requester through the arbiter to the bus driver
	typedef struct packed {
		// register select, low for an instruction and high for character data
		logic rs;
		// byte placed on the eight-bit LCD data bus
		logic [7:0] data;
		// set on the final item of a transfer so the arbiter can release its grant
		logic last;
	} lcdCharReq_t;

	// function set for an eight-bit interface, two display lines and the 5x8 font
	localparam logic [7:0] CMD_FUNCTION_SET = 8'h38;

	// display on with the cursor and blink both off
	localparam logic [7:0] CMD_DISPLAY_ON = 8'h0C;

	// entry mode where the address counter increments and the display never shifts
	localparam logic [7:0] CMD_ENTRY_MODE = 8'h06;

	// clear display, the one command that needs the long settle time
	localparam logic [7:0] CMD_CLEAR = 8'h01;

	// set DDRAM address to the first column of the top row
	localparam logic [7:0] CMD_ROW0_ADDR = 8'h80;

	// set DDRAM address to the first column of the bottom row (DDRAM 0x40)
	localparam logic [7:0] CMD_ROW1_ADDR = 8'hC0;

	// ASCII digits shown for a clear bit and for a set bit
	localparam logic [7:0] CHAR_ZERO = 8'h30;
	localparam logic [7:0] CHAR_ONE = 8'h31;

endpackage

// ==== hdl/lcdTiming_macros.svh ====
`ifndef LCD_TIMING_MACROS_SVH
`define LCD_TIMING_MACROS_SVH

// characters on one display row, one per bit of the shown value
`define LCD_LINE_CHARS 16

// the counts below are in clock cycles and are kept short for simulation
// a board build scales them up to the datasheet times for its clock

// rs and data stable before enable rises
`define LCD_SETUP_CYCLES 2

// width of the enable pulse
`define LCD_PULSE_CYCLES 4

// settle time after an ordinary instruction or character write
`define LCD_WAIT_CYCLES 8

// settle time after the clear display instruction
`define LCD_CLEAR_WAIT_CYCLES 40

// delay from reset release until the first setup command
`define LCD_POWERUP_CYCLES 20

`endif

// ==== hdl/lineFormatter.sv ====
`timescale 1ns/1ns
`include "lcdTiming_macros.svh"

module lineFormatter #(
	// DDRAM address command of the row this instance writes
	parameter logic [7:0] ROW_ADDR = lcdPkg::CMD_ROW0_ADDR
) (
	input logic clock,
	input logic rstN,
	input logic [15:0] lineValue,
	input logic lineValid,
	output logic lineReady,
	output lcdPkg::lcdCharReq_t req,
	output logic reqValid,
	input logic reqReady
);

	// index 0 is the address command, 1 up to LCD_LINE_CHARS are the digits
	localparam int IDX_W = $clog2(`LCD_LINE_CHARS + 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`LCD_LINE_CHARS);

	logic busy;
	logic [IDX_W-1:0] charIdx;
	logic [15:0] shiftVal;
	logic itemDone;

	assign itemDone = reqValid && reqReady;

	// control state, cleared by reset
	always_ff @(posedge clock) begin
		if (!rstN) begin
			busy <= 1'b0;
			charIdx <= '0;
		end else if (!busy) begin
			if (lineValid) begin
				busy <= 1'b1;
				charIdx <= '0;
			end
		end else if (itemDone) begin
			// the row stays owned until its final digit has gone out
			if (charIdx == LAST_IDX)
				busy <= 1'b0;
			else
				charIdx <= charIdx + 1'b1;
		end
	end

	// captured value, shifted so the next digit to send is always in bit 15
	always_ff @(posedge clock) begin
		if (!busy && lineValid)
			shiftVal <= lineValue;
		else if (itemDone && charIdx != '0)
			shiftVal <= {shiftVal[14:0], 1'b0};
	end

	// the address goes out first as an instruction, then the digits MSB first
	always_comb begin
		if (charIdx == '0) begin
			req.rs = 1'b0;
			req.data = ROW_ADDR;
		end else begin
			req.rs = 1'b1;
			req.data = shiftVal[15] ? lcdPkg::CHAR_ONE : lcdPkg::CHAR_ZERO;
		end
		req.last = (charIdx == LAST_IDX);
	end

	// a new value is only taken while no row is in flight
	assign lineReady = !busy;
	assign reqValid = busy;

endmodule

// ==== lcdBinaryDisplay.f ====
+incdir+hdl
hdl/lcdPkg.sv
hdl/lcdInit.sv
hdl/lineFormatter.sv
hdl/lcdArbiter.sv
hdl/lcdBusDriver.sv
hdl/lcdBinaryDisplay.sv
tb/lcdBinaryDisplayTb.sv

// ==== tb/lcdBinaryDisplayTb.sv ====
`timescale 1ns/1ns
`include "lcdTiming_macros.svh"

module lcdBinaryDisplayTb;

	localparam int CLOCK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_RECORDS = 16;
	// one address command plus one digit per bit
	localparam int ROW_ITEMS = `LCD_LINE_CHARS + 1;
	localparam int PULSE_NS = `LCD_PULSE_CYCLES * CLOCK_PERIOD;
	localparam int SETUP_NS = `LCD_SETUP_CYCLES * CLOCK_PERIOD;
	localparam int WAIT_NS = `LCD_WAIT_CYCLES * CLOCK_PERIOD;
	localparam int CLEAR_NS = `LCD_CLEAR_WAIT_CYCLES * CLOCK_PERIOD;
	// every record and the setup transfer at the longest item time and then doubled
	localparam int WATCHDOG_NS = (NUM_RECORDS + 1) * ROW_ITEMS *
		(`LCD_SETUP_CYCLES + `LCD_PULSE_CYCLES + `LCD_CLEAR_WAIT_CYCLES) * CLOCK_PERIOD * 2;
	localparam logic [7:0] INIT_TAG = 8'hFF;

	// one line of the data file with the first display column in the top byte of chars
	typedef struct packed {
		logic [3:0] row;
		logic [15:0] value;
		logic [127:0] chars;
	} record_t;

	// one write the display should latch and the record it belongs to
	typedef struct packed {
		logic [7:0] tag;
		logic rs;
		logic [7:0] data;
	} expWrite_t;

	logic clock = 1'b0;
	logic rstN;
	logic [15:0] line0Value;
	logic line0Valid;
	logic line0Ready;
	logic [15:0] line1Value;
	logic line1Valid;
	logic line1Ready;
	logic lcdOn;
	logic lcdBlon;
	logic lcdRw;
	logic lcdEn;
	logic lcdRs;
	logic [7:0] lcdData;

	logic [147:0] recordMem [NUM_RECORDS];
	record_t records [NUM_RECORDS];
	expWrite_t expQ [$];
	int writesSeen [NUM_RECORDS];
	int recErrors [NUM_RECORDS];
	// record each row is working on, -1 while the row is idle
	int inFlight [2] = '{-1, -1};
	int initSeen;
	int initErrors;
	int resetErrors;
	int pulseErrors;
	int timingErrors;
	int errorCount;
	int passCount;
	int failCount;
	// the arbiter prefers this row when both rows wait and starts with row 0
	int ptrRow;
	logic [31:0] lfsrState = 32'h7ffc_6136;
	time riseTime;
	time fallTime;
	time changeTime;
	int settleNs;
	logic fallSeen = 1'b0;

	lcdBinaryDisplay lcdBinaryDisplay_i (
		.clock(clock),
		.rstN(rstN),
		.line0Value(line0Value),
		.line0Valid(line0Valid),
		.line0Ready(line0Ready),
		.line1Value(line1Value),
		.line1Valid(line1Valid),
		.line1Ready(line1Ready),
		.lcdOn(lcdOn),
		.lcdBlon(lcdBlon),
		.lcdRw(lcdRw),
		.lcdEn(lcdEn),
		.lcdRs(lcdRs),
		.lcdData(lcdData)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// right shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic takeBits(input int n, output logic [7:0] bits);
		int k;
		bits = '0;
		for (k = 0; k < n; k++) begin
			lfsrState = galoisStep(lfsrState);
			bits = {bits[6:0], lfsrState[0]};
		end
	endtask

	function automatic logic rowReady(input int row);
		return (row == 0) ? line0Ready : line1Ready;
	endfunction

	task automatic compareValue(input string sig, input logic [15:0] expVal,
		input logic [15:0] actVal, output logic ok);
		ok = 1'b1;
		assert (actVal === expVal) else begin
			$display("[ERROR] %0t ns: %s expected %h actual %h", $time, sig, expVal, actVal);
			ok = 1'b0;
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errs);
		if (errs == 0) begin
			passCount++;
			$display("test %s: passed", name);
		end else begin
			failCount++;
			$display("test %s: failed with %0d errors", name, errs);
		end
	endtask

	// the row's address command comes first and the record's characters follow in column order
	task automatic queueRecord(input int idx);
		int k;
		expQ.push_back({8'(idx), 1'b0, (records[idx].row == 0) ? 8'h80 : 8'hC0});
		for (k = 0; k < `LCD_LINE_CHARS; k++)
			expQ.push_back({8'(idx), 1'b1, records[idx].chars[127 - 8 * k -: 8]});
	endtask

	// holds valid until the formatter takes the value, so a busy row stalls here
	task automatic submitValue(input int idx);
		int row;
		logic ok;
		row = records[idx].row;
		@(posedge clock);
		#DRIVE_DELAY;
		if (row == 0) begin
			line0Value = records[idx].value;
			line0Valid = 1'b1;
		end else begin
			line1Value = records[idx].value;
			line1Valid = 1'b1;
		end
		@(negedge clock);
		while (!rowReady(row))
			@(negedge clock);
		// the value is taken on this edge
		@(posedge clock);
		inFlight[row] = idx;
		#DRIVE_DELAY;
		if (row == 0)
			line0Valid = 1'b0;
		else
			line1Valid = 1'b0;
		@(negedge clock);
		compareValue((row == 0) ? "line0Ready" : "line1Ready", 16'd0, 16'(rowReady(row)), ok);
		if (!ok)
			recErrors[idx]++;
	endtask

	// a row takes its next value only once every write but its last one has been latched
	task automatic checkRelease(input int row);
		int idx;
		idx = inFlight[row];
		if (rstN === 1'b1 && idx >= 0) begin
			assert (writesSeen[idx] >= ROW_ITEMS - 1) else begin
				$display("line%0dReady rose at %0t ns after %0d of %0d writes of record %0d",
					row, $time, writesSeen[idx], ROW_ITEMS, idx);
				recErrors[idx]++;
				errorCount++;
			end
			inFlight[row] = -1;
		end
	endtask

	always @(posedge line0Ready)
		checkRelease(0);

	always @(posedge line1Ready)
		checkRelease(1);

	// enable rises only after the setup time and after the previous write has settled
	always @(posedge lcdEn) begin
		riseTime = $time;
		if (rstN === 1'b1) begin
			assert ($time - changeTime >= SETUP_NS) else begin
				$display("lcdEn rose at %0t ns only %0d ns after lcdRs or lcdData moved",
					$time, $time - changeTime);
				timingErrors++;
				errorCount++;
			end
			if (fallSeen) begin
				assert ($time - fallTime >= settleNs + SETUP_NS) else begin
					$display("lcdEn rose at %0t ns only %0d ns after the previous write",
						$time, $time - fallTime);
					timingErrors++;
					errorCount++;
				end
			end
		end
	end

	// rs and data have to hold through the enable pulse and the settle time after it
	always @(lcdRs or lcdData) begin
		if (rstN === 1'b1) begin
			assert (lcdEn === 1'b0) else begin
				$display("lcdRs or lcdData changed at %0t ns while lcdEn was high", $time);
				timingErrors++;
				errorCount++;
			end
			if (fallSeen) begin
				assert ($time - fallTime >= settleNs) else begin
					$display("lcdRs or lcdData changed at %0t ns only %0d ns after enable fell",
						$time, $time - fallTime);
					timingErrors++;
					errorCount++;
				end
			end
		end
		changeTime = $time;
	end

	// the display latches on the falling edge of enable, so that is where writes are seen
	always @(negedge lcdEn) begin : captureWrite
		expWrite_t want;
		logic ok;
		time width;
		if (rstN === 1'b1) begin
			width = $time - riseTime;
			compareValue("lcdEn pulse width", 16'(PULSE_NS), width[15:0], ok);
			if (!ok)
				pulseErrors++;
			compareValue("lcdRw", 16'd0, 16'(lcdRw), ok);
			if (!ok)
				pulseErrors++;
			fallTime = $time;
			fallSeen = 1'b1;
			// a clear instruction needs the long settle time and every other write the short one
			settleNs = (lcdRs === 1'b0 && lcdData === 8'h01) ? CLEAR_NS : WAIT_NS;
			assert (expQ.size() != 0) else begin
				$display("unexpected LCD write at %0t ns with rs %b and data %h, nothing was pending",
					$time, lcdRs, lcdData);
				errorCount++;
			end
			if (expQ.size() != 0) begin
				want = expQ.pop_front();
				compareValue("lcdRs", 16'(want.rs), 16'(lcdRs), ok);
				if (want.tag == INIT_TAG) begin
					initErrors += !ok;
					compareValue("lcdData", 16'(want.data), 16'(lcdData), ok);
					initErrors += !ok;
					initSeen++;
					if (initSeen == 4)
						reportTest("setup commands", initErrors);
				end else begin
					recErrors[want.tag] += !ok;
					compareValue("lcdData", 16'(want.data), 16'(lcdData), ok);
					recErrors[want.tag] += !ok;
					writesSeen[want.tag]++;
					if (writesSeen[want.tag] == ROW_ITEMS) begin
						// the other row goes first the next time both are waiting
						ptrRow = (records[want.tag].row == 0) ? 1 : 0;
						reportTest($sformatf("record %0d row %0d value %h", want.tag,
							records[want.tag].row, records[want.tag].value), recErrors[want.tag]);
					end
				end
			end
		end
	end

	initial begin : stimulus
		int i;
		int k;
		int idx;
		logic ok;
		logic [7:0] bits;
		rstN = 1'b0;
		line0Value = '0;
		line0Valid = 1'b0;
		line1Value = '0;
		line1Valid = 1'b0;
		$readmemh("tb/lcdTestdata.txt", recordMem);
		// the expected characters in the file have to be the value's bits with the MSB first
		for (i = 0; i < NUM_RECORDS; i++) begin
			records[i] = recordMem[i];
			assert (records[i].row <= 1) else begin
				$display("record %0d has no row index 0 or 1, the data file did not load", i);
				errorCount++;
			end
			for (k = 0; k < `LCD_LINE_CHARS; k++) begin
				compareValue("testdata character", records[i].value[15 - k] ? 16'h31 : 16'h30,
					16'(records[i].chars[127 - 8 * k -: 8]), ok);
				recErrors[i] += !ok;
			end
		end
		// function set, display on, entry mode and clear are all instructions
		expQ.push_back({INIT_TAG, 1'b0, 8'h38});
		expQ.push_back({INIT_TAG, 1'b0, 8'h0C});
		expQ.push_back({INIT_TAG, 1'b0, 8'h06});
		expQ.push_back({INIT_TAG, 1'b0, 8'h01});
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY rstN = 1'b1;
		// nothing may reach the display before the power-up delay has run out
		repeat (`LCD_POWERUP_CYCLES) begin
			@(negedge clock);
			compareValue("lcdEn", 16'd0, 16'(lcdEn), ok);
			resetErrors += !ok;
			compareValue("lcdOn", 16'd1, 16'(lcdOn), ok);
			resetErrors += !ok;
			compareValue("lcdBlon", 16'd1, 16'(lcdBlon), ok);
			resetErrors += !ok;
		end
		reportTest("reset and power-up outputs", resetErrors);
		wait (initSeen == 4);
		idx = 0;
		while (idx < NUM_RECORDS) begin
			takeBits(3, bits);
			repeat (bits[2:0]) @(posedge clock);
			takeBits(1, bits);
			if (bits[0] && idx + 1 < NUM_RECORDS && records[idx + 1].row != records[idx].row) begin
				// with both rows idle and the bus quiet the pointer alone sets the order
				while (expQ.size() != 0)
					@(posedge clock);
				if (records[idx].row == ptrRow) begin
					queueRecord(idx);
					queueRecord(idx + 1);
				end else begin
					queueRecord(idx + 1);
					queueRecord(idx);
				end
				fork
					submitValue(idx);
					submitValue(idx + 1);
				join
				idx += 2;
			end else begin
				// single submissions are taken in call order
				queueRecord(idx);
				submitValue(idx);
				idx++;
			end
		end
		while (expQ.size() != 0)
			@(posedge clock);
		// leave time for a stray write to show up
		repeat (`LCD_CLEAR_WAIT_CYCLES) @(posedge clock);
		reportTest("bus setup and settle times", timingErrors);
		reportTest("enable pulse width and write select", pulseErrors);
		$display("tests passed %0d failed %0d, check errors %0d", passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before all rows were written", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tb/lcdTestdata.txt ====
// row index, 16-bit value, then the sixteen expected character bytes
// the leftmost byte is the first display column, 30 is '0' and 31 is '1'
0_A5C3_31303130_30313031_31313030_30303131
1_0000_30303030_30303030_30303030_30303030
0_FFFF_31313131_31313131_31313131_31313131
0_1234_30303031_30303130_30303131_30313030
1_8001_31303030_30303030_30303030_30303031
0_7E18_30313131_31313130_30303031_31303030
1_FEDC_31313131_31313130_31313031_31313030
1_0F0F_30303030_31313131_30303030_31313131
0_5555_30313031_30313031_30313031_30313031
1_AAAA_31303130_31303130_31303130_31303130
0_0001_30303030_30303030_30303030_30303031
1_8000_31303030_30303030_30303030_30303030
1_3C69_30303131_31313030_30313130_31303031
0_B7D2_31303131_30313131_31313031_30303130
1_6E9B_30313130_31313130_31303031_31303131
0_4096_30313030_30303030_31303031_30313130
